//--- design/fx_decode.sv
`include "fx_params.svh"

module fx_decode
	import spu_isa_pkg::*;
	import fx_pipe_pkg::*;
(
	input  logic [`OP_WIDTH-1:0]  op,
	input  format_e               format,
	input  reg_addr_t             rt_addr,
	input  quad_t                 ra,
	input  quad_t                 rb,
	input  logic [`IMM_WIDTH-1:0] imm,
	input  logic                  reg_write,
	input  logic                  branch_taken,
	fx_issue_if.decode            issue
);
	typedef struct packed {
		alu_op_e    op;
		elem_size_e size;
	} dec_t;

	dec_t                    dec;
	logic                    is_op;
	logic [`IMM10_WIDTH-1:0] imm10;
	logic [`HALF_WIDTH-1:0]  imm_half;
	lane_word_t              imm_word;
	quad_t                   imm_quad;

	// imm10 sits in the low bits of the immediate field
	assign imm10 = imm[`IMM10_WIDTH-1:0];
	assign imm_half = {{(`HALF_WIDTH - `IMM10_WIDTH){imm10[`IMM10_WIDTH-1]}}, imm10};
	assign imm_word = {{(`LANE_WIDTH - `IMM10_WIDTH){imm10[`IMM10_WIDTH-1]}}, imm10};
	// same value in every element of the quadword
	assign imm_quad = (dec.size == HALF) ? {(`QUAD_WIDTH / `HALF_WIDTH){imm_half}}
		: {`NUM_LANES{imm_word}};

	always_comb begin
		// anything not matched below stays a bubble
		dec = '{NONE, WORD};
		case (format)
			FMT_RR: begin
				// nop has op 0, falls to default
				case (op)
					OP_A:     dec = '{ADD_SAT, WORD};
					OP_AH:    dec = '{ADD_SAT, HALF};
					OP_SF:    dec = '{SUBF_SAT, WORD};
					OP_SFH:   dec = '{SUBF_SAT, HALF};
					OP_AND:   dec = '{AND, WORD};
					OP_OR:    dec = '{OR, WORD};
					OP_XOR:   dec = '{XOR, WORD};
					OP_NAND:  dec = '{NAND, WORD};
					OP_CEQ:   dec = '{CMP_EQ, WORD};
					OP_CEQH:  dec = '{CMP_EQ, HALF};
					OP_CEQB:  dec = '{CMP_EQ, BYTE};
					OP_CGT:   dec = '{CMP_GT, WORD};
					OP_CGTH:  dec = '{CMP_GT, HALF};
					OP_CGTB:  dec = '{CMP_GT, BYTE};
					OP_CLGT:  dec = '{CMP_LGT, WORD};
					OP_CLGTH: dec = '{CMP_LGT, HALF};
					OP_CLGTB: dec = '{CMP_LGT, BYTE};
					default:  dec = '{NONE, WORD};
				endcase
			end
			FMT_RI10: begin
				if (op[`OP_WIDTH-1:`RI10_OP_WIDTH] == '0) begin
					case (op[`RI10_OP_WIDTH-1:0])
						OP_AI:     dec = '{ADD_SAT, WORD};
						OP_AHI:    dec = '{ADD_SAT, HALF};
						OP_SFI:    dec = '{SUBF_SAT, WORD};
						OP_SFHI:   dec = '{SUBF_SAT, HALF};
						OP_ANDI:   dec = '{AND, WORD};
						OP_ANDHI:  dec = '{AND, HALF};
						OP_ORI:    dec = '{OR, WORD};
						OP_ORHI:   dec = '{OR, HALF};
						OP_XORI:   dec = '{XOR, WORD};
						OP_XORHI:  dec = '{XOR, HALF};
						OP_CEQI:   dec = '{CMP_EQ, WORD};
						OP_CEQHI:  dec = '{CMP_EQ, HALF};
						OP_CGTI:   dec = '{CMP_GT, WORD};
						OP_CGTHI:  dec = '{CMP_GT, HALF};
						OP_CLGTI:  dec = '{CMP_LGT, WORD};
						OP_CLGTHI: dec = '{CMP_LGT, HALF};
						default:   dec = '{NONE, WORD};
					endcase
				end
			end
			default: dec = '{NONE, WORD};
		endcase
		// taken branch squashes the slot
		if (branch_taken) begin
			dec = '{NONE, WORD};
		end
	end

	assign is_op = (dec.op != NONE);

	assign issue.alu_op    = dec.op;
	assign issue.elem_size = dec.size;
	assign issue.opnd_a    = ra;
	assign issue.opnd_b    = (format == FMT_RI10) ? imm_quad : rb;
	// bubbles carry no destination
	assign issue.rt_addr   = is_op ? rt_addr : '0;
	assign issue.reg_write = is_op & reg_write;

endmodule

//--- design/fx_issue_if.sv
// decoded issue, one per cycle, no handshake
interface fx_issue_if
	import fx_pipe_pkg::*;
(
	input logic clk,
	input logic reset
);
	alu_op_e    alu_op;
	elem_size_e elem_size;
	// ra as is
	quad_t      opnd_a;
	// rb or the replicated immediate
	quad_t      opnd_b;
	// zero for a bubble
	reg_addr_t  rt_addr;
	logic       reg_write;

	// decoder drives everything
	modport decode (output alu_op, elem_size, opnd_a, opnd_b, rt_addr, reg_write);

	// lanes see operands, clock only for checks
	modport lane (input clk, reset, alu_op, elem_size, opnd_a, opnd_b);

	// writeback only needs destination info
	modport wb (input alu_op, rt_addr, reg_write);

endinterface

//--- design/fx_lane.sv
`include "fx_params.svh"

module fx_lane
	import fx_pipe_pkg::*;
#(
	parameter int lane_idx = 0
) (
	fx_issue_if.lane   issue,
	output lane_word_t result
);
	typedef logic [`BYTE_WIDTH-1:0] byte_t;
	typedef logic [`HALF_WIDTH-1:0] half_t;

	lane_word_t a;
	lane_word_t b;

	// one element of width w, x and y zero-extended into a lane word
	function automatic lane_word_t elem_calc(input alu_op_e op, input int w,
			input lane_word_t x, input lane_word_t y);
		logic signed [`LANE_WIDTH+1:0] sign_bit;
		logic signed [`LANE_WIDTH+1:0] sx;
		logic signed [`LANE_WIDTH+1:0] sy;
		logic signed [`LANE_WIDTH+1:0] full;
		lane_word_t                    ones;
		lane_word_t                    r;
		sign_bit = '0;
		sign_bit[w-1] = 1'b1;
		// low w bits set, all-ones compare result
		ones = lane_word_t'((sign_bit <<< 1) - 1);
		// flip and subtract the sign bit to get the signed value
		sx = ($signed({2'b00, x}) ^ sign_bit) - sign_bit;
		sy = ($signed({2'b00, y}) ^ sign_bit) - sign_bit;
		full = '0;
		case (op)
			ADD_SAT, SUBF_SAT: begin
				// two extra bits hold any sum without wrap
				full = (op == ADD_SAT) ? sx + sy : sy - sx;
				if (full > sign_bit - 1) begin
					full = sign_bit - 1;
				end
				else if (full < -sign_bit) begin
					full = -sign_bit;
				end
				r = lane_word_t'(full) & ones;
			end
			AND:     r = x & y;
			OR:      r = x | y;
			XOR:     r = x ^ y;
			// upper bits beyond w stay clear
			NAND:    r = ~(x & y) & ones;
			CMP_EQ:  r = (x == y) ? ones : '0;
			CMP_GT:  r = (sx > sy) ? ones : '0;
			// unsigned, zero-extended operands compare directly
			CMP_LGT: r = (x > y) ? ones : '0;
			default: r = '0;
		endcase
		return r;
	endfunction

	// this lane's slice of both operands
	assign a = issue.opnd_a[lane_idx*`LANE_WIDTH +: `LANE_WIDTH];
	assign b = issue.opnd_b[lane_idx*`LANE_WIDTH +: `LANE_WIDTH];

	always_comb begin
		result = '0;
		case (issue.elem_size)
			BYTE: begin
				for (int e = 0; e < `LANE_WIDTH / `BYTE_WIDTH; e++) begin
					result[e*`BYTE_WIDTH +: `BYTE_WIDTH] = byte_t'(elem_calc(issue.alu_op,
						`BYTE_WIDTH, lane_word_t'(a[e*`BYTE_WIDTH +: `BYTE_WIDTH]),
						lane_word_t'(b[e*`BYTE_WIDTH +: `BYTE_WIDTH])));
				end
			end
			HALF: begin
				for (int e = 0; e < `LANE_WIDTH / `HALF_WIDTH; e++) begin
					result[e*`HALF_WIDTH +: `HALF_WIDTH] = half_t'(elem_calc(issue.alu_op,
						`HALF_WIDTH, lane_word_t'(a[e*`HALF_WIDTH +: `HALF_WIDTH]),
						lane_word_t'(b[e*`HALF_WIDTH +: `HALF_WIDTH])));
				end
			end
			default: begin
				result = elem_calc(issue.alu_op, `LANE_WIDTH, a, b);
			end
		endcase
	end

	// decoder never asks for byte-sized saturating arithmetic
	a_arith_not_byte: assert property (@(posedge issue.clk) disable iff (issue.reset)
		(issue.alu_op inside {ADD_SAT, SUBF_SAT}) |-> (issue.elem_size != BYTE));

	// decode always resolves to a defined operation
	a_op_known: assert property (@(posedge issue.clk) disable iff (issue.reset)
		!$isunknown(issue.alu_op));

endmodule

//--- design/fx_pipe_pkg.sv
`include "fx_params.svh"

package fx_pipe_pkg;

	// operation seen by the lanes after decode
	typedef enum logic [3:0] {
		ADD_SAT  = 4'd0,
		SUBF_SAT = 4'd1,
		AND      = 4'd2,
		OR       = 4'd3,
		XOR      = 4'd4,
		NAND     = 4'd5,
		CMP_EQ   = 4'd6,
		CMP_GT   = 4'd7,
		CMP_LGT  = 4'd8,
		// bubble, result forced to zero
		NONE     = 4'd9
	} alu_op_e;

	// how a lane splits its word
	typedef enum logic [1:0] {
		BYTE = 2'd0,
		HALF = 2'd1,
		WORD = 2'd2
	} elem_size_e;

	typedef logic [`LANE_WIDTH-1:0] lane_word_t;

	typedef logic [`QUAD_WIDTH-1:0] quad_t;

	// lane k covers bits k*32 upward
	typedef lane_word_t [`NUM_LANES-1:0] lane_array_t;

	typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

endpackage

//--- design/fx_writeback.sv
module fx_writeback
	import fx_pipe_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	fx_issue_if.wb      issue,
	input  lane_array_t lane_result,
	input  reg_addr_t   ra_odd_addr,
	input  reg_addr_t   rb_odd_addr,
	input  reg_addr_t   ra_even_addr,
	input  reg_addr_t   rb_even_addr,
	input  reg_addr_t   rc_even_addr,
	output quad_t       rt_wb,
	output reg_addr_t   rt_addr_wb,
	output logic        reg_write_wb,
	output logic        stall_odd_raw,
	output logic        stall_even_raw
);
	quad_t     rt_s0;
	quad_t     rt_s1;
	reg_addr_t addr_s0;
	reg_addr_t addr_s1;
	logic      wr_s0;
	logic      wr_s1;
	logic      wr_next;

	// only a real operation may write
	assign wr_next = issue.reg_write && (issue.alu_op != NONE);

	always_ff @(posedge clk) begin
		if (reset) begin
			rt_s0   <= '0;
			addr_s0 <= '0;
			wr_s0   <= 1'b0;
			rt_s1   <= '0;
			addr_s1 <= '0;
			wr_s1   <= 1'b0;
		end
		else begin
			// stage 0 takes the lane results of this issue
			rt_s0   <= lane_result;
			addr_s0 <= issue.rt_addr;
			wr_s0   <= wr_next;
			// stage 1 feeds the register file
			rt_s1   <= rt_s0;
			addr_s1 <= addr_s0;
			wr_s1   <= wr_s0;
		end
	end

	assign rt_wb        = rt_s1;
	assign rt_addr_wb   = addr_s1;
	assign reg_write_wb = wr_s1;

	// RAW against the instruction issued last cycle
	assign stall_odd_raw = wr_s0 &&
		((addr_s0 == ra_odd_addr) || (addr_s0 == rb_odd_addr));
	assign stall_even_raw = wr_s0 &&
		((addr_s0 == ra_even_addr) || (addr_s0 == rb_even_addr) || (addr_s0 == rc_even_addr));

	// no write leaks out of reset
	a_wb_clear_after_reset: assert property (@(posedge clk) reset |=> !reg_write_wb);

	// a stall needs a writing issue one cycle earlier
	a_stall_needs_writer: assert property (@(posedge clk) disable iff (reset)
		(stall_odd_raw || stall_even_raw) |-> $past(issue.reg_write));

endmodule

//--- design/simple_fixed1.sv
`include "fx_params.svh"

module simple_fixed1
	import spu_isa_pkg::*;
	import fx_pipe_pkg::*;
(
	input  logic                       clk,
	input  logic                       reset,
	input  logic [`OP_WIDTH-1:0]       op,
	input  logic [`FORMAT_WIDTH-1:0]   format,
	input  logic [`REG_ADDR_WIDTH-1:0] rt_addr,
	input  logic [`QUAD_WIDTH-1:0]     ra,
	input  logic [`QUAD_WIDTH-1:0]     rb,
	input  logic [`IMM_WIDTH-1:0]      imm,
	input  logic                       reg_write,
	input  logic                       branch_taken,
	input  logic [`REG_ADDR_WIDTH-1:0] ra_odd_addr,
	input  logic [`REG_ADDR_WIDTH-1:0] rb_odd_addr,
	input  logic [`REG_ADDR_WIDTH-1:0] ra_even_addr,
	input  logic [`REG_ADDR_WIDTH-1:0] rb_even_addr,
	input  logic [`REG_ADDR_WIDTH-1:0] rc_even_addr,
	output logic [`QUAD_WIDTH-1:0]     rt_wb,
	output logic [`REG_ADDR_WIDTH-1:0] rt_addr_wb,
	output logic                       reg_write_wb,
	output logic                       stall_odd_raw,
	output logic                       stall_even_raw
);
	lane_array_t lane_result;

	fx_issue_if issue_if (
		.clk   (clk),
		.reset (reset)
	);

	// unknown formats pass through the cast and decode as bubbles
	fx_decode i_decode (
		.op           (op),
		.format       (format_e'(format)),
		.rt_addr      (rt_addr),
		.ra           (ra),
		.rb           (rb),
		.imm          (imm),
		.reg_write    (reg_write),
		.branch_taken (branch_taken),
		.issue        (issue_if)
	);

	// one 32-bit slice per lane
	for (genvar k = 0; k < `NUM_LANES; k++) begin : g_lane
		fx_lane #(
			.lane_idx (k)
		) i_lane (
			.issue  (issue_if),
			.result (lane_result[k])
		);
	end

	fx_writeback i_writeback (
		.clk            (clk),
		.reset          (reset),
		.issue          (issue_if),
		.lane_result    (lane_result),
		.ra_odd_addr    (ra_odd_addr),
		.rb_odd_addr    (rb_odd_addr),
		.ra_even_addr   (ra_even_addr),
		.rb_even_addr   (rb_even_addr),
		.rc_even_addr   (rc_even_addr),
		.rt_wb          (rt_wb),
		.rt_addr_wb     (rt_addr_wb),
		.reg_write_wb   (reg_write_wb),
		.stall_odd_raw  (stall_odd_raw),
		.stall_even_raw (stall_even_raw)
	);

endmodule

//--- design/spu_isa_pkg.sv
`include "fx_params.svh"

package spu_isa_pkg;

	// formats this pipe executes, the others turn into bubbles
	typedef enum logic [`FORMAT_WIDTH-1:0] {
		FMT_RR   = 0,
		FMT_RI10 = 4
	} format_e;

	// register-register opcodes, full 11-bit field
	typedef enum logic [`OP_WIDTH-1:0] {
		OP_NOP   = 11'b00000000000,
		OP_A     = 11'b00011000000,
		OP_AH    = 11'b00011001000,
		OP_SF    = 11'b00001000000,
		OP_SFH   = 11'b00001001000,
		OP_AND   = 11'b00011000001,
		OP_OR    = 11'b00001000001,
		OP_XOR   = 11'b01001000001,
		OP_NAND  = 11'b00011001001,
		OP_CEQ   = 11'b01111000000,
		OP_CEQH  = 11'b01111001000,
		OP_CEQB  = 11'b01111010000,
		OP_CGT   = 11'b01001000000,
		OP_CGTH  = 11'b01001001000,
		OP_CGTB  = 11'b01001010000,
		OP_CLGT  = 11'b01011000000,
		OP_CLGTH = 11'b01011001000,
		OP_CLGTB = 11'b01011010000
	} rr_opcode_e;

	// RI10 opcodes, upper three op bits must be zero
	typedef enum logic [`RI10_OP_WIDTH-1:0] {
		OP_AI     = 8'b00011100,
		OP_AHI    = 8'b00011101,
		OP_SFI    = 8'b00001100,
		OP_SFHI   = 8'b00001101,
		OP_ANDI   = 8'b00010100,
		OP_ANDHI  = 8'b00010101,
		OP_ORI    = 8'b00000100,
		OP_ORHI   = 8'b00000101,
		OP_XORI   = 8'b01000100,
		OP_XORHI  = 8'b01000101,
		OP_CEQI   = 8'b01111100,
		OP_CEQHI  = 8'b01111101,
		OP_CGTI   = 8'b01001100,
		OP_CGTHI  = 8'b01001101,
		OP_CLGTI  = 8'b01011100,
		OP_CLGTHI = 8'b01011101
	} ri10_opcode_e;

endpackage

//--- include/fx_params.svh
`ifndef FX_PARAMS_SVH
`define FX_PARAMS_SVH

// full register width of the SIMD datapath
`define QUAD_WIDTH 128

// one ALU slice handles a word
`define LANE_WIDTH 32

// element widths inside a lane
`define HALF_WIDTH 16
`define BYTE_WIDTH 8

// lanes needed to cover one quadword
`define NUM_LANES (`QUAD_WIDTH / `LANE_WIDTH)

// register file has 128 entries
`define REG_ADDR_WIDTH 7

// opcode field as delivered by the decoder, truncated per format
`define OP_WIDTH 11
// RI10 opcodes occupy the low bits of the op field
`define RI10_OP_WIDTH 8

// instruction format selector
`define FORMAT_WIDTH 3

// immediate field, and the signed immediate of the RI10 format
`define IMM_WIDTH 18
`define IMM10_WIDTH 10

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the fixed-point pipe testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module tb_simple_fixed1 -f vlog.f -o tb_sim

./obj_dir/tb_sim | tee sim.log

grep -q "Simulation completed successfully" sim.log

//--- testbench/fx_checker.sv
`include "fx_params.svh"

module fx_checker
	import spu_isa_pkg::*;
	import fx_pipe_pkg::*;
(
	input  logic                       clk,
	input  logic                       reset,
	input  logic [`OP_WIDTH-1:0]       op,
	input  logic [`FORMAT_WIDTH-1:0]   format,
	input  logic [`REG_ADDR_WIDTH-1:0] rt_addr,
	input  quad_t                      ra,
	input  quad_t                      rb,
	input  logic [`IMM_WIDTH-1:0]      imm,
	input  logic                       reg_write,
	input  logic                       branch_taken,
	input  logic [`REG_ADDR_WIDTH-1:0] ra_odd_addr,
	input  logic [`REG_ADDR_WIDTH-1:0] rb_odd_addr,
	input  logic [`REG_ADDR_WIDTH-1:0] ra_even_addr,
	input  logic [`REG_ADDR_WIDTH-1:0] rb_even_addr,
	input  logic [`REG_ADDR_WIDTH-1:0] rc_even_addr,
	input  quad_t                      rt_wb,
	input  logic [`REG_ADDR_WIDTH-1:0] rt_addr_wb,
	input  logic                       reg_write_wb,
	input  logic                       stall_odd_raw,
	input  logic                       stall_even_raw,
	output int                         value_errors,
	output int                         stall_errors,
	output int                         checks
);
	timeunit 1ns;
	timeprecision 1ps;

	// operation and element width in bits
	typedef struct {
		alu_op_e kind;
		int      w;
	} op_info_t;

	// what writeback should show for one issue
	typedef struct packed {
		quad_t     val;
		reg_addr_t addr;
		logic      wr;
	} expect_t;

	// entries for the two issues in flight
	expect_t   pend[$];
	logic      prev_wr;
	reg_addr_t prev_addr;

	// anything not listed here, or a taken branch, is a bubble
	function automatic op_info_t decode_opcode(input logic [`FORMAT_WIDTH-1:0] fmt,
			input logic [`OP_WIDTH-1:0] opc, input logic br);
		op_info_t d;
		d = '{NONE, 32};
		if (!br && fmt == FMT_RR) begin
			case (opc)
				OP_A:     d = '{ADD_SAT, 32};
				OP_AH:    d = '{ADD_SAT, 16};
				OP_SF:    d = '{SUBF_SAT, 32};
				OP_SFH:   d = '{SUBF_SAT, 16};
				OP_AND:   d = '{AND, 32};
				OP_OR:    d = '{OR, 32};
				OP_XOR:   d = '{XOR, 32};
				OP_NAND:  d = '{NAND, 32};
				OP_CEQ:   d = '{CMP_EQ, 32};
				OP_CEQH:  d = '{CMP_EQ, 16};
				OP_CEQB:  d = '{CMP_EQ, 8};
				OP_CGT:   d = '{CMP_GT, 32};
				OP_CGTH:  d = '{CMP_GT, 16};
				OP_CGTB:  d = '{CMP_GT, 8};
				OP_CLGT:  d = '{CMP_LGT, 32};
				OP_CLGTH: d = '{CMP_LGT, 16};
				OP_CLGTB: d = '{CMP_LGT, 8};
				default:  d = '{NONE, 32};
			endcase
		end
		else if (!br && fmt == FMT_RI10 && opc[10:8] == 3'b000) begin
			case (opc[7:0])
				OP_AI:     d = '{ADD_SAT, 32};
				OP_AHI:    d = '{ADD_SAT, 16};
				OP_SFI:    d = '{SUBF_SAT, 32};
				OP_SFHI:   d = '{SUBF_SAT, 16};
				OP_ANDI:   d = '{AND, 32};
				OP_ANDHI:  d = '{AND, 16};
				OP_ORI:    d = '{OR, 32};
				OP_ORHI:   d = '{OR, 16};
				OP_XORI:   d = '{XOR, 32};
				OP_XORHI:  d = '{XOR, 16};
				OP_CEQI:   d = '{CMP_EQ, 32};
				OP_CEQHI:  d = '{CMP_EQ, 16};
				OP_CGTI:   d = '{CMP_GT, 32};
				OP_CGTHI:  d = '{CMP_GT, 16};
				OP_CLGTI:  d = '{CMP_LGT, 32};
				OP_CLGTHI: d = '{CMP_LGT, 16};
				default:   d = '{NONE, 32};
			endcase
		end
		return d;
	endfunction

	// element by element over the whole quadword
	function automatic quad_t predict_result(input op_info_t d, input logic [2:0] fmt,
			input quad_t a, input quad_t b, input logic [`IMM_WIDTH-1:0] im);
		longint mask;
		longint lim;
		longint simm;
		longint x;
		longint y;
		longint sx;
		longint sy;
		longint r;
		quad_t  res;
		mask = (longint'(1) << d.w) - 1;
		// magnitude of the most negative element
		lim = longint'(1) << (d.w - 1);
		simm = longint'($signed(im[`IMM10_WIDTH-1:0])) & mask;
		res = '0;
		for (int i = 0; i < `QUAD_WIDTH / d.w; i++) begin
			x = longint'(a >> (i * d.w)) & mask;
			y = (fmt == FMT_RI10) ? simm : (longint'(b >> (i * d.w)) & mask);
			sx = (x >= lim) ? x - 2 * lim : x;
			sy = (y >= lim) ? y - 2 * lim : y;
			case (d.kind)
				ADD_SAT:  r = sx + sy;
				// subtract-from, b minus a
				SUBF_SAT: r = sy - sx;
				AND:      r = x & y;
				OR:       r = x | y;
				XOR:      r = x ^ y;
				NAND:     r = ~(x & y);
				CMP_EQ:   r = (x == y) ? mask : 0;
				CMP_GT:   r = (sx > sy) ? mask : 0;
				CMP_LGT:  r = (x > y) ? mask : 0;
				default:  r = 0;
			endcase
			// clamp to the signed range of the element
			if (d.kind inside {ADD_SAT, SUBF_SAT}) begin
				if (r > lim - 1) begin
					r = lim - 1;
				end
				else if (r < -lim) begin
					r = -lim;
				end
			end
			res = res | (quad_t'(r & mask) << (i * d.w));
		end
		return res;
	endfunction

	initial begin
		value_errors = 0;
		stall_errors = 0;
		checks = 0;
	end

	// all reads here see the values from before the edge, same as the DUT
	always @(posedge clk) begin
		expect_t  e;
		expect_t  head;
		op_info_t d;
		logic     exp_odd;
		logic     exp_even;
		if (reset) begin
			// cleared stages show up as two zero results
			pend.delete();
			pend.push_back('0);
			pend.push_back('0);
			prev_wr = 1'b0;
			prev_addr = '0;
		end
		else begin
			// writeback holds the issue captured two edges ago
			head = pend.pop_front();
			checks++;
			if (rt_wb !== head.val || rt_addr_wb !== head.addr || reg_write_wb !== head.wr) begin
				value_errors++;
				$display("FAIL at %0t ns: writeback got %h addr %0d wr %b, expected %h addr %0d wr %b",
					$time, rt_wb, rt_addr_wb, reg_write_wb, head.val, head.addr, head.wr);
			end
			// hazards come from the issue captured at the previous edge
			exp_odd = prev_wr && (prev_addr == ra_odd_addr || prev_addr == rb_odd_addr);
			exp_even = prev_wr && (prev_addr == ra_even_addr || prev_addr == rb_even_addr
				|| prev_addr == rc_even_addr);
			if (stall_odd_raw !== exp_odd || stall_even_raw !== exp_even) begin
				stall_errors++;
				$display("FAIL at %0t ns: stall odd/even got %b/%b, expected %b/%b",
					$time, stall_odd_raw, stall_even_raw, exp_odd, exp_even);
			end
			d = decode_opcode(format, op, branch_taken);
			e.wr = (d.kind != NONE) && reg_write;
			e.addr = (d.kind != NONE) ? rt_addr : '0;
			e.val = (d.kind != NONE) ? predict_result(d, format, ra, rb, imm) : '0;
			pend.push_back(e);
			prev_wr = e.wr;
			prev_addr = e.addr;
		end
	end

endmodule

//--- testbench/tb_simple_fixed1.sv
`include "fx_params.svh"

module tb_simple_fixed1
	import spu_isa_pkg::*;
	import fx_pipe_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int RESET_CYCLES = 10;
	localparam int N_PAT = 6;
	localparam int N_BUBBLE = 5;
	localparam int N_RANDOM = 2000;

	logic                       clk = 1'b0;
	logic                       reset;
	logic [`OP_WIDTH-1:0]       op;
	logic [`FORMAT_WIDTH-1:0]   format;
	logic [`REG_ADDR_WIDTH-1:0] rt_addr;
	quad_t                      ra;
	quad_t                      rb;
	logic [`IMM_WIDTH-1:0]      imm;
	logic                       reg_write;
	logic                       branch_taken;
	logic [`REG_ADDR_WIDTH-1:0] ra_odd_addr;
	logic [`REG_ADDR_WIDTH-1:0] rb_odd_addr;
	logic [`REG_ADDR_WIDTH-1:0] ra_even_addr;
	logic [`REG_ADDR_WIDTH-1:0] rb_even_addr;
	logic [`REG_ADDR_WIDTH-1:0] rc_even_addr;
	quad_t                      rt_wb;
	logic [`REG_ADDR_WIDTH-1:0] rt_addr_wb;
	logic                       reg_write_wb;
	logic                       stall_odd_raw;
	logic                       stall_even_raw;
	int                         value_errors;
	int                         stall_errors;
	int                         checks;

	integer seed = 32'hf672_ebfd;
	int     cycle_count = 0;
	int     timeout_limit = 1000000;

	// {format, op} of every kept instruction
	logic [13:0] op_list[$];

	// word patterns at the saturation limits and top-bit differences
	lane_word_t pat_a[N_PAT] = '{32'h7fff_ffff, 32'h8000_0000, 32'h8000_8000,
		32'h7fff_7fff, 32'h8080_8080, 32'h1234_ffff};
	lane_word_t pat_b[N_PAT] = '{32'h7fff_ffff, 32'h8000_0000, 32'h7fff_7fff,
		32'h8000_8000, 32'h0080_0080, 32'h1234_ffff};
	// upper immediate bits in the last two are ignored
	logic [`IMM_WIDTH-1:0] pat_imm[N_PAT] = '{18'h001ff, 18'h00200, 18'h003ff,
		18'h00155, 18'h3fe00, 18'h3ffff};

	// nop, bad rr opcode, bad format, ri10 with high op bits, taken branch
	logic [13:0] bubbles[N_BUBBLE] = '{{FMT_RR, OP_NOP}, {FMT_RR, 11'h7ff}, {3'd2, OP_A},
		{FMT_RI10, 11'h71c}, {FMT_RR, OP_A}};

	always #2 clk = ~clk;

	simple_fixed1 i_simple_fixed1 (.*);

	fx_checker i_checker (.*);

	function automatic quad_t rand_quad();
		return {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	// one issue per rising edge, addresses kept small so hazards are common
	task automatic drive_issue(input logic [13:0] fo, input quad_t a, input quad_t b,
			input logic [`IMM_WIDTH-1:0] im, input logic br);
		@(posedge clk);
		format <= fo[13:11];
		op <= fo[10:0];
		ra <= a;
		rb <= b;
		imm <= im;
		branch_taken <= br;
		reg_write <= ($random(seed) & 3) != 0;
		rt_addr <= 7'($random(seed) & 15);
		ra_odd_addr <= 7'($random(seed) & 15);
		rb_odd_addr <= 7'($random(seed) & 15);
		ra_even_addr <= 7'($random(seed) & 15);
		rb_even_addr <= 7'($random(seed) & 15);
		rc_even_addr <= 7'($random(seed) & 15);
	endtask

	// run limit
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", timeout_limit);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		logic [13:0]  fo;
		logic [31:0]  r;
		quad_t        qa;
		quad_t        qb;
		rr_opcode_e   rr;
		ri10_opcode_e ri;
		reset = 1'b1;
		// a writing add sits on the inputs through reset, cleared stages must hide it
		op = OP_A;
		format = FMT_RR;
		rt_addr = 7'd3;
		ra = {4{32'h0000_0001}};
		rb = {4{32'h0000_0002}};
		imm = '0;
		reg_write = 1'b1;
		branch_taken = 1'b0;
		// source addresses hit that destination on both pipes
		ra_odd_addr = 7'd3;
		rb_odd_addr = '0;
		ra_even_addr = '0;
		rb_even_addr = '0;
		rc_even_addr = 7'd3;
		// kept opcodes straight from the enums
		rr = rr.first();
		repeat (rr.num()) begin
			if (rr != OP_NOP) begin
				op_list.push_back({FMT_RR, rr});
			end
			rr = rr.next();
		end
		ri = ri.first();
		repeat (ri.num()) begin
			op_list.push_back({FMT_RI10, 3'b000, ri});
			ri = ri.next();
		end
		// reset, all issues, drain and some slack
		timeout_limit = RESET_CYCLES + op_list.size() * N_PAT + N_BUBBLE + N_RANDOM + 50;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		// directed: every kept opcode against every pattern
		foreach (op_list[i]) begin
			for (int p = 0; p < N_PAT; p++) begin
				drive_issue(op_list[i], {4{pat_a[p]}}, {4{pat_b[p]}}, pat_imm[p], 1'b0);
			end
		end
		for (int i = 0; i < N_BUBBLE; i++) begin
			drive_issue(bubbles[i], {4{pat_a[0]}}, {4{pat_b[0]}}, pat_imm[0], i == N_BUBBLE - 1);
		end
		// random mix with some raw encodings and taken branches
		repeat (N_RANDOM) begin
			r = $random(seed);
			qa = rand_quad();
			if (r[6:4] == 0) begin
				qb = qa;
			end
			else if (r[6:4] == 1) begin
				qb = qa ^ {16{8'h80}};
			end
			else begin
				qb = rand_quad();
			end
			if (r[3:0] == 0) begin
				fo = 14'($random(seed));
			end
			else begin
				fo = op_list[$unsigned($random(seed)) % op_list.size()];
			end
			drive_issue(fo, qa, qb, 18'($random(seed)), r[11:8] == 0);
		end
		// flush the two in flight
		repeat (3) drive_issue(14'd0, '0, '0, '0, 1'b0);
		@(negedge clk);
		$display("checks: %0d, value errors: %0d, stall errors: %0d",
			checks, value_errors, stall_errors);
		if (value_errors == 0 && stall_errors == 0) begin
			$display("Simulation completed successfully");
		end
		else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- vlog.f
+incdir+include
design/spu_isa_pkg.sv
design/fx_pipe_pkg.sv
design/fx_issue_if.sv
design/fx_decode.sv
design/fx_lane.sv
design/fx_writeback.sv
design/simple_fixed1.sv
testbench/fx_checker.sv
testbench/tb_simple_fixed1.sv
